//--- include/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// register and datapath width
`define EXU_XLEN 64

// shift amount width for the 64-bit shifts
`define EXU_SHAMT_W 6

// one step per operand bit in the mul/div unit
`define EXU_MD_STEPS 64

// cycle limit for bounded waits in simulation
`define EXU_TIMEOUT 2000

`endif

//--- design/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // major opcodes handled by the execute unit
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

    // funct7 values of the register forms
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // same instruction word, register or immediate layout
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } rv_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // encoded as funct3 of the M extension
    typedef enum logic [2:0] {
        MD_MUL,
        MD_MULH,
        MD_MULHSU,
        MD_MULHU,
        MD_DIV,
        MD_DIVU,
        MD_REM,
        MD_REMU
    } md_op_e;

endpackage

`default_nettype wire

//--- design/exu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [31:0]            instr,
    input  logic [`EXU_XLEN-1:0]   rs1_val,
    input  logic [`EXU_XLEN-1:0]   rs2_val,
    input  logic                   res_ready,
    input  logic                   md_done,
    output logic                   in_ready,
    output logic                   dec_valid,
    output logic                   is_md,
    output logic                   is_word,
    output exu_pkg::alu_op_e       alu_op,
    output exu_pkg::md_op_e        md_op,
    output logic [`EXU_XLEN-1:0]   opa,
    output logic [`EXU_XLEN-1:0]   opb,
    output logic                   md_start
);

    exu_pkg::rv_instr_u     ins;
    logic [2:0]             f3;
    logic [11:0]            imm;
    logic [`EXU_XLEN-1:0]   imm_sx;
    logic                   base_f7;
    logic                   alt_ok;
    logic                   ok;
    logic                   d_md;
    logic                   d_word;
    exu_pkg::alu_op_e       d_alu;
    exu_pkg::md_op_e        d_mdop;
    logic [`EXU_XLEN-1:0]   d_a;
    logic [`EXU_XLEN-1:0]   d_b;
    logic                   hand_off;
    logic                   md_issued; // unit is working on the held item

    function automatic exu_pkg::alu_op_e alu_map(input logic [2:0] fn, input logic alt);
        case (fn)
            3'b000:  alu_map = alt ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
            3'b001:  alu_map = exu_pkg::ALU_SLL;
            3'b010:  alu_map = exu_pkg::ALU_SLT;
            3'b011:  alu_map = exu_pkg::ALU_SLTU;
            3'b100:  alu_map = exu_pkg::ALU_XOR;
            3'b101:  alu_map = alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
            3'b110:  alu_map = exu_pkg::ALU_OR;
            default: alu_map = exu_pkg::ALU_AND;
        endcase
    endfunction

    assign ins     = instr;
    assign f3      = ins.r.funct3;
    assign imm     = ins.i.imm12;
    assign imm_sx  = {{(`EXU_XLEN-12){imm[11]}}, imm};
    assign base_f7 = (ins.r.funct7 == exu_pkg::F7_BASE);
    assign alt_ok  = (ins.r.funct7 == exu_pkg::F7_ALT) && (f3 == 3'b000 || f3 == 3'b101);

    always_comb begin
        ok     = 1'b0;
        d_md   = 1'b0;
        d_word = 1'b0;
        d_alu  = exu_pkg::ALU_ADD;
        d_mdop = exu_pkg::md_op_e'(f3);
        d_a    = rs1_val;
        d_b    = rs2_val;
        case (ins.r.opcode)
            exu_pkg::OPC_OP: begin
                if (ins.r.funct7 == exu_pkg::F7_MULDIV) begin
                    ok   = 1'b1;
                    d_md = 1'b1;
                end else if (base_f7 || alt_ok) begin
                    ok    = 1'b1;
                    d_alu = alu_map(f3, ins.r.funct7[5]);
                end
            end
            exu_pkg::OPC_OP_IMM: begin
                d_b   = imm_sx;
                d_alu = alu_map(f3, f3 == 3'b101 && imm[10]);
                if (f3 == 3'b001)
                    ok = (imm[11:6] == 6'b000000);
                else if (f3 == 3'b101)
                    ok = (imm[11:6] == 6'b000000) || (imm[11:6] == 6'b010000);
                else
                    ok = 1'b1;
            end
            exu_pkg::OPC_OP_32: begin
                d_word = 1'b1;
                if (ins.r.funct7 == exu_pkg::F7_MULDIV) begin
                    ok   = (f3 == 3'b000) || f3[2]; // mulw and the four divides
                    d_md = 1'b1;
                end else if (base_f7 || alt_ok) begin
                    ok    = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101);
                    d_alu = alu_map(f3, ins.r.funct7[5]);
                end
            end
            exu_pkg::OPC_OP_IMM_32: begin
                d_word = 1'b1;
                d_b    = imm_sx;
                d_alu  = alu_map(f3, f3 == 3'b101 && imm[10]);
                ok     = (f3 == 3'b000)
                      || (f3 == 3'b001 && imm[11:5] == 7'b0000000)
                      || (f3 == 3'b101 && (imm[11:5] == 7'b0000000 || imm[11:5] == 7'b0100000));
            end
            default: ok = 1'b0;
        endcase

        if (d_word) begin
            // unsigned word divides need the low words zero extended
            if (d_md && (d_mdop == exu_pkg::MD_DIVU || d_mdop == exu_pkg::MD_REMU)) begin
                d_a = {{(`EXU_XLEN-32){1'b0}}, d_a[31:0]};
                d_b = {{(`EXU_XLEN-32){1'b0}}, d_b[31:0]};
            end else begin
                d_a = {{(`EXU_XLEN-32){d_a[31]}}, d_a[31:0]};
                d_b = {{(`EXU_XLEN-32){d_b[31]}}, d_b[31:0]};
            end
            if (!d_md && (d_alu == exu_pkg::ALU_SLL || d_alu == exu_pkg::ALU_SRL
                          || d_alu == exu_pkg::ALU_SRA))
                d_b = {{(`EXU_XLEN-5){1'b0}}, d_b[4:0]}; // 5-bit shamt
        end

        if (!ok) begin // unsupported, add of zeros
            d_md   = 1'b0;
            d_word = 1'b0;
            d_alu  = exu_pkg::ALU_ADD;
            d_a    = '0;
            d_b    = '0;
        end
    end

    assign hand_off = (dec_valid && !is_md && res_ready) || md_done;
    assign in_ready = !dec_valid || hand_off;
    assign md_start = dec_valid && is_md && !md_issued && res_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            is_md     <= 1'b0;
            is_word   <= 1'b0;
            md_issued <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                dec_valid <= 1'b1;
                is_md     <= d_md;
                is_word   <= d_word;
            end else if (hand_off) begin
                dec_valid <= 1'b0;
            end
            if (md_start)
                md_issued <= 1'b1;
            else if (md_done)
                md_issued <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            alu_op <= d_alu;
            md_op  <= d_mdop;
            opa    <= d_a;
            opb    <= d_b;
        end
    end

endmodule

`default_nettype wire

//--- design/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_alu (
    input  exu_pkg::alu_op_e       alu_op,
    input  logic [`EXU_XLEN-1:0]   opa,
    input  logic [`EXU_XLEN-1:0]   opb,
    input  logic                   is_word,
    output logic [`EXU_XLEN-1:0]   alu_result
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt = opb[`EXU_SHAMT_W-1:0]; // word shifts arrive already narrowed
    assign lt_s  = ($signed(opa) < $signed(opb));
    assign lt_u  = (opa < opb);

    always_comb begin
        case (alu_op)
            exu_pkg::ALU_ADD:  alu_result = opa + opb;
            exu_pkg::ALU_SUB:  alu_result = opa - opb;
            exu_pkg::ALU_SLL:  alu_result = opa << shamt;
            exu_pkg::ALU_SLT:  alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU: alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:  alu_result = opa ^ opb;
            exu_pkg::ALU_SRL: begin
                // srlw must not pull the sign copies into bit 31
                if (is_word)
                    alu_result = {{(`EXU_XLEN-32){1'b0}}, opa[31:0]} >> shamt;
                else
                    alu_result = opa >> shamt;
            end
            exu_pkg::ALU_SRA: begin
                // low word with its sign
                if (is_word)
                    alu_result = $signed({{(`EXU_XLEN-32){opa[31]}}, opa[31:0]}) >>> shamt;
                else
                    alu_result = $signed(opa) >>> shamt;
            end
            exu_pkg::ALU_OR:   alu_result = opa | opb;
            exu_pkg::ALU_AND:  alu_result = opa & opb;
            default:           alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/exu_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_muldiv (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   md_start,
    input  exu_pkg::md_op_e        md_op,
    input  logic [`EXU_XLEN-1:0]   opa,
    input  logic [`EXU_XLEN-1:0]   opb,
    input  logic                   is_word,
    output logic                   md_busy,
    output logic                   md_done,
    output logic [`EXU_XLEN-1:0]   md_result
);

    localparam int XL    = `EXU_XLEN;
    localparam int CNT_W = $clog2(`EXU_MD_STEPS) + 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`EXU_MD_STEPS);

    logic [CNT_W-1:0]  cnt;
    logic [2*XL-1:0]   acc;       // product hi:lo, or remainder:quotient
    logic [XL-1:0]     mag_b_q;
    exu_pkg::md_op_e   op_q;
    logic              neg_a_q;
    logic              neg_b_q;
    logic              div_zero_q;
    logic              word_q;
    logic              a_signed;
    logic              b_signed;
    logic              neg_a;
    logic              neg_b;
    logic [XL-1:0]     mag_a;
    logic [XL-1:0]     mag_b;
    logic              is_div;
    logic [XL:0]       add_sum;
    logic [XL:0]       rem_sh;
    logic [XL:0]       trial;
    logic [2*XL-1:0]   mul_next;
    logic [2*XL-1:0]   div_next;
    logic [2*XL-1:0]   prod;
    logic [XL-1:0]     quot;
    logic [XL-1:0]     rem;
    logic [XL-1:0]     res;

    assign a_signed = (md_op == exu_pkg::MD_MULH) || (md_op == exu_pkg::MD_MULHSU)
                   || (md_op == exu_pkg::MD_DIV) || (md_op == exu_pkg::MD_REM);
    assign b_signed = (md_op == exu_pkg::MD_MULH) || (md_op == exu_pkg::MD_DIV)
                   || (md_op == exu_pkg::MD_REM);
    assign neg_a    = a_signed && opa[XL-1];
    assign neg_b    = b_signed && opb[XL-1];
    assign mag_a    = neg_a ? -opa : opa;
    assign mag_b    = neg_b ? -opb : opb;
    assign is_div   = op_q[2]; // div/rem group

    // shift-add step, multiplier sits in the low half
    assign add_sum  = {1'b0, acc[2*XL-1:XL]} + (acc[0] ? {1'b0, mag_b_q} : '0);
    assign mul_next = {add_sum, acc[XL-1:1]};

    // restoring step, keep the shifted remainder if the trial goes negative
    assign rem_sh   = {acc[2*XL-1:XL], acc[XL-1]};
    assign trial    = rem_sh - {1'b0, mag_b_q};
    assign div_next = trial[XL] ? {rem_sh[XL-1:0], acc[XL-2:0], 1'b0}
                                : {trial[XL-1:0], acc[XL-2:0], 1'b1};

    // sign fix-up; overflow falls out of the magnitudes on its own
    assign prod = (neg_a_q ^ neg_b_q) ? -acc : acc;
    assign quot = div_zero_q ? '1 : ((neg_a_q ^ neg_b_q) ? -acc[XL-1:0] : acc[XL-1:0]);
    assign rem  = neg_a_q ? -acc[2*XL-1:XL] : acc[2*XL-1:XL];

    always_comb begin
        case (op_q)
            exu_pkg::MD_MUL:    res = prod[XL-1:0];
            exu_pkg::MD_MULH,
            exu_pkg::MD_MULHSU,
            exu_pkg::MD_MULHU:  res = prod[2*XL-1:XL];
            exu_pkg::MD_DIV,
            exu_pkg::MD_DIVU:   res = quot;
            default:            res = rem;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_busy <= 1'b0;
            md_done <= 1'b0;
            cnt     <= '0;
        end else begin
            md_done <= 1'b0;
            if (md_start) begin
                md_busy <= 1'b1;
                cnt     <= '0;
            end else if (md_busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin // finishing cycle
                    md_busy <= 1'b0;
                    md_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            op_q       <= md_op;
            neg_a_q    <= neg_a;
            neg_b_q    <= neg_b;
            div_zero_q <= (opb == '0);
            word_q     <= is_word;
            mag_b_q    <= mag_b;
            acc        <= {{XL{1'b0}}, mag_a};
        end else if (md_busy && cnt != LAST) begin
            acc <= is_div ? div_next : mul_next;
        end
        if (md_busy && cnt == LAST)
            md_result <= word_q ? {{(XL-32){1'b0}}, res[31:0]} : res;
    end

endmodule

`default_nettype wire

//--- design/exu_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dec_valid,
    input  logic                   is_md,
    input  logic                   is_word,
    input  logic [`EXU_XLEN-1:0]   alu_result,
    input  logic                   md_done,
    input  logic [`EXU_XLEN-1:0]   md_result,
    input  logic                   out_ready,
    output logic                   res_ready,
    output logic                   out_valid,
    output logic [`EXU_XLEN-1:0]   rd_val
);

    logic                 alu_take;
    logic                 load;
    logic [`EXU_XLEN-1:0] sel;
    logic [`EXU_XLEN-1:0] ext;

    assign res_ready = !out_valid || out_ready;
    assign alu_take  = dec_valid && !is_md && res_ready;
    assign load      = alu_take || md_done; // never both, decode holds one item

    assign sel = md_done ? md_result : alu_result;
    assign ext = is_word ? {{(`EXU_XLEN-32){sel[31]}}, sel[31:0]} : sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load)
            rd_val <= ext;
    end

endmodule

`default_nettype wire

//--- design/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [31:0]            instr,
    input  logic [`EXU_XLEN-1:0]   rs1_val,
    input  logic [`EXU_XLEN-1:0]   rs2_val,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output logic [`EXU_XLEN-1:0]   rd_val
);

    logic                 dec_valid;
    logic                 is_md;
    logic                 is_word;
    exu_pkg::alu_op_e     alu_op;
    exu_pkg::md_op_e      md_op;
    logic [`EXU_XLEN-1:0] opa;
    logic [`EXU_XLEN-1:0] opb;
    logic                 md_start;
    logic                 md_done;
    logic [`EXU_XLEN-1:0] md_result;
    logic [`EXU_XLEN-1:0] alu_result;
    logic                 res_ready;

    exu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .res_ready (res_ready),
        .md_done   (md_done),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .is_md     (is_md),
        .is_word   (is_word),
        .alu_op    (alu_op),
        .md_op     (md_op),
        .opa       (opa),
        .opb       (opb),
        .md_start  (md_start)
    );

    exu_alu u_alu (
        .alu_op     (alu_op),
        .opa        (opa),
        .opb        (opb),
        .is_word    (is_word),
        .alu_result (alu_result)
    );

    // idle tracking lives in decode, busy is left open
    exu_muldiv u_muldiv (
        .clk       (clk),
        .rst_n     (rst_n),
        .md_start  (md_start),
        .md_op     (md_op),
        .opa       (opa),
        .opb       (opb),
        .is_word   (is_word),
        .md_busy   (),
        .md_done   (md_done),
        .md_result (md_result)
    );

    exu_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .is_md      (is_md),
        .is_word    (is_word),
        .alu_result (alu_result),
        .md_done    (md_done),
        .md_result  (md_result),
        .out_ready  (out_ready),
        .res_ready  (res_ready),
        .out_valid  (out_valid),
        .rd_val     (rd_val)
    );

endmodule

`default_nettype wire

//--- dv/exu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_ready,
    input  logic [31:0]          instr,
    input  logic [`EXU_XLEN-1:0] exp_val,
    input  logic                 out_valid,
    input  logic                 out_ready,
    input  logic [`EXU_XLEN-1:0] rd_val,
    output int                   n_outputs,
    output int                   n_passed,
    output int                   n_failed
);

    logic [31:0]          pend_instr[$]; // accepted and waiting for a result
    logic [`EXU_XLEN-1:0] pend_exp[$];
    int                   n_inputs;
    logic                 idle_bad;      // handshake seen wrong before the first input

    task automatic retire_output();
        logic [31:0]          ins;
        logic [`EXU_XLEN-1:0] want;
        n_outputs++;
        if (pend_exp.size() == 0) begin
            $display("error: result %h came out at %0t with no input waiting for it",
                     rd_val, $time);
            n_failed++;
        end else begin
            ins  = pend_instr.pop_front();
            want = pend_exp.pop_front();
            if (rd_val !== want) begin
                $display("Fail at %0t: test %0d instr %h expected %h got %h",
                         $time, n_outputs, ins, want, rd_val);
                n_failed++;
            end else begin
                $display("pass: test %0d instr %h result %h", n_outputs, ins, rd_val);
                n_passed++;
            end
        end
    endtask

    task automatic report_reset_state();
        if (!idle_bad) begin
            $display("pass: reset state, out_valid low and in_ready high");
            n_passed++;
        end
    endtask

    // inputs settle well before the falling edge
    initial begin
        n_outputs = 0;
        n_passed  = 0;
        n_failed  = 0;
        n_inputs  = 0;
        idle_bad  = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (n_inputs == 0 && !idle_bad && (out_valid || !in_ready)) begin
                    $display("error: out_valid high or in_ready low at %0t before any input",
                             $time);
                    n_failed++;
                    idle_bad = 1'b1;
                end
                if (out_valid && out_ready) // retire the older item first
                    retire_output();
                if (in_valid && in_ready) begin
                    if (n_inputs == 0)
                        report_reset_state();
                    pend_instr.push_back(instr);
                    pend_exp.push_back(exp_val);
                    n_inputs++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_tb;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    logic [31:0]          instr;
    logic [`EXU_XLEN-1:0] rs1_val;
    logic [`EXU_XLEN-1:0] rs2_val;
    logic [`EXU_XLEN-1:0] exp_val; // rides along with the input, checker only
    logic                 out_ready;
    logic                 in_ready;
    logic                 out_valid;
    logic [`EXU_XLEN-1:0] rd_val;
    int                   n_outputs;
    int                   n_passed;
    int                   n_failed;

    logic [31:0]          case_instr[$];
    logic [`EXU_XLEN-1:0] case_a[$];
    logic [`EXU_XLEN-1:0] case_b[$];
    logic [`EXU_XLEN-1:0] case_exp[$];
    int                   n_sent;
    int                   n_timeouts;
    logic                 file_ok;
    logic [31:0]          seed_draw;

    always #10 clk = ~clk;

    exu_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .rd_val    (rd_val)
    );

    exu_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr     (instr),
        .exp_val   (exp_val),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rd_val    (rd_val),
        .n_outputs (n_outputs),
        .n_passed  (n_passed),
        .n_failed  (n_failed)
    );

    task automatic load_cases();
        int                   fd;
        int                   got;
        string                line;
        logic [31:0]          c_instr;
        logic [`EXU_XLEN-1:0] c_a;
        logic [`EXU_XLEN-1:0] c_b;
        logic [`EXU_XLEN-1:0] c_exp;
        fd = $fopen("dv/exu_cases.txt", "r");
        if (fd == 0) begin
            $display("error: could not open dv/exu_cases.txt");
            file_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && line.getc(0) != 8'h23) begin // '#' starts a comment line
                got = $sscanf(line, "%h %h %h %h", c_instr, c_a, c_b, c_exp);
                if (got == 4) begin
                    case_instr.push_back(c_instr);
                    case_a.push_back(c_a);
                    case_b.push_back(c_b);
                    case_exp.push_back(c_exp);
                end
            end
        end
        $fclose(fd);
        file_ok = 1'b1;
    endtask

    // holds the item until accepted, in_ready looked at mid-cycle
    task automatic send_case(input int idx);
        int   waited;
        logic accepted;
        instr    = case_instr[idx];
        rs1_val  = case_a[idx];
        rs2_val  = case_b[idx];
        exp_val  = case_exp[idx];
        in_valid = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < `EXU_TIMEOUT) begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #1;
            waited++;
        end
        in_valid = 1'b0;
        if (accepted) begin
            n_sent++;
        end else begin
            $display("timeout: input %0d was not accepted within %0d cycles",
                     idx, `EXU_TIMEOUT);
            n_timeouts++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (n_outputs < n_sent && waited < `EXU_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (n_outputs < n_sent) begin
            $display("timeout: only %0d of %0d results came out within %0d cycles",
                     n_outputs, n_sent, `EXU_TIMEOUT);
            n_timeouts++;
        end
    endtask

    // random back-pressure, mostly ready
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = (($urandom % 4) != 0);
        end
    end

    initial begin
        seed_draw  = $urandom(32'hcd74);
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        instr      = '0;
        rs1_val    = '0;
        rs2_val    = '0;
        exp_val    = '0;
        n_sent     = 0;
        n_timeouts = 0;
        file_ok    = 1'b0;
        load_cases();

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(2); // lets the checker see the idle state

        for (int i = 0; i < case_instr.size() && n_timeouts == 0; i++) begin
            send_case(i);
            if (($urandom % 4) == 0)
                idle_cycles(int'($urandom % 3) + 1);
        end
        if (n_timeouts == 0)
            wait_drain();
        idle_cycles(10); // catches any extra result

        $display("summary: %0d inputs, %0d results, %0d passed, %0d failed, %0d timeouts",
                 n_sent, n_outputs, n_passed, n_failed, n_timeouts);
        if (file_ok && n_sent > 0 && n_failed == 0 && n_timeouts == 0 && n_outputs == n_sent)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
design/exu_pkg.sv
design/exu_decode.sv
design/exu_alu.sv
design/exu_muldiv.sv
design/exu_result.sv
design/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module exu_tb -f verilog.f --Mdir obj_dir -o exu_sim

./obj_dir/exu_sim > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- dv/exu_cases.txt
# columns: instruction, rs1 value, rs2 value, expected rd value, all hex
# rs2 is unused by immediate forms; the last case is an unsupported opcode
003100b3 7fffffffffffffff 0000000000000001 8000000000000000
023100b3 ffffffffffffffff 0000000000000005 fffffffffffffffb
403100b3 0000000000000000 0000000000000001 ffffffffffffffff
023110b3 8000000000000000 0000000000000002 ffffffffffffffff
003110b3 0000000000000001 0000000000000043 0000000000000008
003120b3 8000000000000000 0000000000000001 0000000000000001
003130b3 8000000000000000 0000000000000001 0000000000000000
023120b3 ffffffffffffffff ffffffffffffffff ffffffffffffffff
023130b3 ffffffffffffffff ffffffffffffffff fffffffffffffffe
003140b3 0f0f0f0f0f0f0f0f ffff0000ffff0000 f0f00f0ff0f00f0f
003150b3 8000000000000000 000000000000003f 0000000000000001
403150b3 8000000000000000 0000000000000004 f800000000000000
003160b3 00000000000000f0 000000000000000f 00000000000000ff
003170b3 123456789abcdef0 00000000ffffffff 000000009abcdef0
023140b3 fffffffffffffff9 0000000000000002 fffffffffffffffd
fff10093 0000000000000000 0000000000000000 ffffffffffffffff
00012093 fffffffffffffffe 0000000000000000 0000000000000001
023160b3 fffffffffffffff9 0000000000000002 ffffffffffffffff
00411093 0fffffffffffffff 0000000000000000 fffffffffffffff0
03c15093 a000000000000000 0000000000000000 000000000000000a
40815093 8000000000000000 0000000000000000 ff80000000000000
023150b3 ffffffffffffffff 0000000000000010 0fffffffffffffff
023170b3 ffffffffffffffff 0000000000000010 000000000000000f
003100bb 000000007fffffff 0000000000000001 ffffffff80000000
403100bb 0000000100000000 0000000000000001 ffffffffffffffff
003110bb 0000000000000001 000000000000003f ffffffff80000000
003150bb ffffffff80000000 0000000000000004 0000000008000000
403150bb 0000000080000000 0000000000000004 fffffffff8000000
0011009b 00000000ffffffff 0000000000000000 0000000000000000
023100bb 0000000000008000 0000000000010000 ffffffff80000000
023140b3 0000000000001234 0000000000000000 ffffffffffffffff
023150b3 0000000000000005 0000000000000000 ffffffffffffffff
023160b3 fffffffffffffff9 0000000000000000 fffffffffffffff9
023170b3 0000000000001234 0000000000000000 0000000000001234
023140b3 8000000000000000 ffffffffffffffff 8000000000000000
023160b3 8000000000000000 ffffffffffffffff 0000000000000000
023140bb 00000000fffffff9 0000000000000002 fffffffffffffffd
023150bb 0000000000000007 0000000000000000 ffffffffffffffff
023140bb 0000000080000000 00000000ffffffff ffffffff80000000
023160bb 0000000080000000 00000000ffffffff 0000000000000000
023170bb 00000000fffffff9 0000000000000010 0000000000000009
023160bb 00000000fffffff9 0000000000000000 fffffffffffffff9
000000b7 0000000000000005 0000000000000006 0000000000000000
